// File: logic/board_io_config.svh
`ifndef BOARD_IO_CONFIG_SVH
`define BOARD_IO_CONFIG_SVH

// board resources
`define BOARD_IO_N_SWITCHES 10
`define BOARD_IO_N_KEYS 2
`define BOARD_IO_N_LEDS 10
`define BOARD_IO_N_DIGITS 6

// clocks an input must hold before it is accepted
`define BOARD_IO_DEBOUNCE_CYCLES 16

// register bus
`define BOARD_IO_ADDR_W 8
`define BOARD_IO_DATA_W 32

`endif

// File: logic/board_io_pkg.sv
`include "board_io_config.svh"

package board_io_pkg;

    // register word addresses
    typedef enum logic [`BOARD_IO_ADDR_W-1:0] {
        REG_SWITCHES = 8'h00,
        REG_KEYS     = 8'h04,
        REG_LEDS     = 8'h08,
        REG_HEX      = 8'h0C,
        REG_BLANK    = 8'h10
    } io_reg_e;

    // one hex digit value
    typedef logic [3:0] hex_nibble_t;

    // active-low segments, g down to a
    typedef logic [6:0] segments_t;

endpackage

// File: logic/io_bus_if.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

interface io_bus_if;

    logic [`BOARD_IO_ADDR_W-1:0] addr;
    logic [`BOARD_IO_DATA_W-1:0] wdata;
    logic                        wr;
    logic                        rd;
    logic [`BOARD_IO_DATA_W-1:0] rdata;

    // processor side
    modport master (
        output addr,
        output wdata,
        output wr,
        output rd,
        input  rdata
    );

    // register file side
    modport slave (
        input  addr,
        input  wdata,
        input  wr,
        input  rd,
        output rdata
    );

endinterface

// File: logic/input_debouncer.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

module input_debouncer #(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] stable
);

    localparam int CNT_W = $clog2(`BOARD_IO_DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`BOARD_IO_DEBOUNCE_CYCLES - 1);

    logic [WIDTH-1:0] sync_meta;
    logic [WIDTH-1:0] sync_q;
    logic [CNT_W-1:0] stable_cnt [WIDTH];

    // two-flop synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= raw;
            sync_q    <= sync_meta;
        end
    end

    // counter runs only while the synced bit disagrees with stable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_q[i] == stable[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_LAST) begin
                    // held long enough, accept it
                    stable[i]     <= sync_q[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/io_reg_file.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

module io_reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    io_bus_if.slave                          bus,
    input  logic [`BOARD_IO_N_SWITCHES-1:0]  switches,
    input  logic [`BOARD_IO_N_KEYS-1:0]      keys,
    output logic [`BOARD_IO_N_LEDS-1:0]      leds,
    output logic [4*`BOARD_IO_N_DIGITS-1:0]  hex_value,
    output logic [`BOARD_IO_N_DIGITS-1:0]    blank
);

    import board_io_pkg::*;

    localparam int DATA_W = `BOARD_IO_DATA_W;
    localparam int HEX_W  = 4 * `BOARD_IO_N_DIGITS;

    io_reg_e           reg_addr;
    logic [DATA_W-1:0] rd_mux;

    assign reg_addr = io_reg_e'(bus.addr);

    // register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leds      <= '0;
            hex_value <= '0;
            // displays start dark
            blank     <= '1;
        end else if (bus.wr) begin
            case (reg_addr)
                REG_LEDS: begin
                    leds <= bus.wdata[`BOARD_IO_N_LEDS-1:0];
                end
                REG_HEX: begin
                    hex_value <= bus.wdata[HEX_W-1:0];
                end
                REG_BLANK: begin
                    blank <= bus.wdata[`BOARD_IO_N_DIGITS-1:0];
                end
                default: begin
                    // read-only or unmapped, write dropped
                end
            endcase
        end
    end

    // read data select, unused bits zero
    always_comb begin
        case (reg_addr)
            REG_SWITCHES: begin
                rd_mux = {{(DATA_W - `BOARD_IO_N_SWITCHES){1'b0}}, switches};
            end
            REG_KEYS: begin
                rd_mux = {{(DATA_W - `BOARD_IO_N_KEYS){1'b0}}, keys};
            end
            REG_LEDS: begin
                rd_mux = {{(DATA_W - `BOARD_IO_N_LEDS){1'b0}}, leds};
            end
            REG_HEX: begin
                rd_mux = {{(DATA_W - HEX_W){1'b0}}, hex_value};
            end
            REG_BLANK: begin
                rd_mux = {{(DATA_W - `BOARD_IO_N_DIGITS){1'b0}}, blank};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // rdata holds until the next read strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.rdata <= '0;
        end else if (bus.rd) begin
            bus.rdata <= rd_mux;
        end
    end

endmodule

// File: logic/seven_seg_digit.sv
`timescale 1ns/1ps

module seven_seg_digit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  board_io_pkg::hex_nibble_t value,
    input  logic                     blank,
    output board_io_pkg::segments_t   seg
);

    import board_io_pkg::*;

    segments_t pattern;

    // active low, bit 6 is g and bit 0 is a
    always_comb begin
        case (value)
            4'h0: pattern = 7'b1000000;
            4'h1: pattern = 7'b1111001;
            4'h2: pattern = 7'b0100100;
            4'h3: pattern = 7'b0110000;
            4'h4: pattern = 7'b0011001;
            4'h5: pattern = 7'b0010010;
            4'h6: pattern = 7'b0000010;
            4'h7: pattern = 7'b1111000;
            4'h8: pattern = 7'b0000000;
            4'h9: pattern = 7'b0010000;
            4'hA: pattern = 7'b0001000;
            4'hB: pattern = 7'b0000011;
            4'hC: pattern = 7'b1000110;
            4'hD: pattern = 7'b0100001;
            4'hE: pattern = 7'b0000110;
            default: pattern = 7'b0001110;
        endcase
    end

    // all segments off when blanked
    always_ff @(posedge clk) begin
        if (!rst_n || blank) begin
            seg <= '1;
        end else begin
            seg <= pattern;
        end
    end

endmodule

// File: logic/board_io_top.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

module board_io_top (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [`BOARD_IO_N_SWITCHES-1:0] sw,
    input  logic [`BOARD_IO_N_KEYS-1:0]     key,

    input  logic [`BOARD_IO_ADDR_W-1:0]     bus_addr,
    input  logic [`BOARD_IO_DATA_W-1:0]     bus_wdata,
    input  logic                            bus_wr,
    input  logic                            bus_rd,
    output logic [`BOARD_IO_DATA_W-1:0]     bus_rdata,

    output logic [`BOARD_IO_N_LEDS-1:0]     ledr,
    output logic [7:0]                      hex0,
    output logic [7:0]                      hex1,
    output logic [7:0]                      hex2,
    output logic [7:0]                      hex3,
    output logic [7:0]                      hex4,
    output logic [7:0]                      hex5
);

    import board_io_pkg::*;

    localparam int N_IN = `BOARD_IO_N_SWITCHES + `BOARD_IO_N_KEYS;

    logic [N_IN-1:0]                     raw_in;
    logic [N_IN-1:0]                     clean_in;
    logic [4*`BOARD_IO_N_DIGITS-1:0]     hex_value;
    logic [`BOARD_IO_N_DIGITS-1:0]       blank;
    segments_t                           digit_seg [`BOARD_IO_N_DIGITS];

    // keys are active low, pressed reads as 1
    assign raw_in = {~key, sw};

    io_bus_if io_bus_if_i ();

    // master side driven straight from the board bus pins
    assign io_bus_if_i.addr  = bus_addr;
    assign io_bus_if_i.wdata = bus_wdata;
    assign io_bus_if_i.wr    = bus_wr;
    assign io_bus_if_i.rd    = bus_rd;
    assign bus_rdata         = io_bus_if_i.rdata;

    input_debouncer #(
        .WIDTH (N_IN)
    ) input_debouncer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw    (raw_in),
        .stable (clean_in)
    );

    io_reg_file io_reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (io_bus_if_i.slave),
        .switches  (clean_in[`BOARD_IO_N_SWITCHES-1:0]),
        .keys      (clean_in[N_IN-1:`BOARD_IO_N_SWITCHES]),
        .leds      (ledr),
        .hex_value (hex_value),
        .blank     (blank)
    );

    // one decoder per nibble, digit 0 is the low nibble
    for (genvar d = 0; d < `BOARD_IO_N_DIGITS; d++) begin : gen_digit
        seven_seg_digit seven_seg_digit_i (
            .clk   (clk),
            .rst_n (rst_n),
            .value (hex_value[4*d +: 4]),
            .blank (blank[d]),
            .seg   (digit_seg[d])
        );
    end

    // decimal points unused, held dark
    assign hex0 = {1'b1, digit_seg[0]};
    assign hex1 = {1'b1, digit_seg[1]};
    assign hex2 = {1'b1, digit_seg[2]};
    assign hex3 = {1'b1, digit_seg[3]};
    assign hex4 = {1'b1, digit_seg[4]};
    assign hex5 = {1'b1, digit_seg[5]};

endmodule

// File: sim/board_io_assertions.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

module board_io_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input logic [`BOARD_IO_ADDR_W-1:0]       bus_addr,
    input logic [`BOARD_IO_DATA_W-1:0]       bus_wdata,
    input logic                              bus_wr,
    input logic                              bus_rd,
    input logic [`BOARD_IO_DATA_W-1:0]       bus_rdata,
    input logic [`BOARD_IO_N_LEDS-1:0]       ledr,
    input logic [4*`BOARD_IO_N_DIGITS-1:0]   hex_value,
    input logic [`BOARD_IO_N_DIGITS-1:0]     blank,
    input logic [7:0]                        hex0,
    input logic [7:0]                        hex1,
    input logic [7:0]                        hex2,
    input logic [7:0]                        hex3,
    input logic [7:0]                        hex4,
    input logic [7:0]                        hex5
);

    import board_io_pkg::*;

    // lit segments per digit value, segment a in bit 0
    localparam logic [6:0] LIT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    int         error_count = 0;
    logic [7:0] hex_port [`BOARD_IO_N_DIGITS];

    assign hex_port[0] = hex0;
    assign hex_port[1] = hex1;
    assign hex_port[2] = hex2;
    assign hex_port[3] = hex3;
    assign hex_port[4] = hex4;
    assign hex_port[5] = hex5;

    function automatic segments_t expected_seg(input hex_nibble_t v, input logic off);
        return off ? 7'h7F : ~LIT[v];
    endfunction

    led_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        bus_wr && bus_addr == REG_LEDS |=> ledr == $past(bus_wdata[`BOARD_IO_N_LEDS-1:0]))
    else begin
        $error("ledr does not show the written LED value");
        error_count++;
    end

    rdata_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_rd |=> $stable(bus_rdata))
    else begin
        $error("rdata changed without a read strobe");
        error_count++;
    end

    reset_clear_a: assert property (@(posedge clk)
        !$past(rst_n) && rst_n |-> ledr == '0 && bus_rdata == '0)
    else begin
        $error("LED or rdata register not cleared by reset");
        error_count++;
    end

    // registered decode, so the port follows last cycle's nibble and blank bit
    for (genvar d = 0; d < `BOARD_IO_N_DIGITS; d++) begin : gen_digit_chk
        digit_a: assert property (@(posedge clk) $past(rst_n) |->
            hex_port[d] == {1'b1, expected_seg($past(hex_value[4*d +: 4]), $past(blank[d]))})
        else begin
            $error("digit %0d shows a wrong segment pattern", d);
            error_count++;
        end
    end

endmodule

bind board_io_top board_io_assertions board_io_assertions_i (.*);

// File: sim/board_io_tb.sv
`timescale 1ns/1ps
`include "board_io_config.svh"

module board_io_tb;

    import board_io_pkg::*;

    // summed test length with margin
    localparam int MAX_CYCLES = 1200;

    logic                            clk;
    logic                            rst_n;
    logic [`BOARD_IO_N_SWITCHES-1:0] sw;
    logic [`BOARD_IO_N_KEYS-1:0]     key;
    logic [`BOARD_IO_ADDR_W-1:0]     bus_addr;
    logic [`BOARD_IO_DATA_W-1:0]     bus_wdata;
    logic                            bus_wr;
    logic                            bus_rd;
    logic [`BOARD_IO_DATA_W-1:0]     bus_rdata;
    logic [`BOARD_IO_N_LEDS-1:0]     ledr;
    logic [7:0]                      hex [`BOARD_IO_N_DIGITS];

    logic [15:0] lfsr_state;
    int          cycles;
    int          test_errors;
    int          assert_mark;
    int          tests_passed;
    int          tests_failed;

    board_io_top board_io_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sw        (sw),
        .key       (key),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_rdata (bus_rdata),
        .ledr      (ledr),
        .hex0      (hex[0]),
        .hex1      (hex[1]),
        .hex2      (hex[2]),
        .hex3      (hex[3]),
        .hex4      (hex[4]),
        .hex5      (hex[5])
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, cycle limit of %0d reached", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic bus_write(input io_reg_e addr, input logic [31:0] data);
        @(posedge clk);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_wr    <= 1'b1;
        @(posedge clk);
        bus_wr    <= 1'b0;
    endtask

    task automatic bus_read(input io_reg_e addr, output logic [31:0] data);
        @(posedge clk);
        bus_addr <= addr;
        bus_rd   <= 1'b1;
        @(posedge clk);
        bus_rd   <= 1'b0;
        // rdata registered on the strobe edge, stable here
        @(posedge clk);
        data = bus_rdata;
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic read_expect(input io_reg_e addr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        bus_read(addr, got);
        compare(what, got, exp);
    endtask

    task automatic begin_test();
        test_errors = 0;
        assert_mark = board_io_top_i.board_io_assertions_i.error_count;
    endtask

    task automatic end_test(input string name);
        int fired;
        fired = board_io_top_i.board_io_assertions_i.error_count - assert_mark;
        if (test_errors == 0 && fired == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d wrong values, %0d assertion failures",
                     name, test_errors, fired);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] val;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sw           = '0;
        key          = '1;
        bus_addr     = '0;
        bus_wdata    = '0;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        lfsr_state   = 16'd27;
        cycles       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        @(posedge clk);
        compare("ledr", ledr, '0);
        for (int d = 0; d < `BOARD_IO_N_DIGITS; d++) begin
            compare("hex port", hex[d], 8'hFF);
        end
        read_expect(REG_SWITCHES, '0, "switches");
        end_test("reset_state");

        begin_test();
        take_bits(`BOARD_IO_N_LEDS, val);
        bus_write(REG_LEDS, val);
        @(posedge clk);
        compare("ledr", ledr, val);
        read_expect(REG_LEDS, val, "led register");
        end_test("led_write");

        begin_test();
        take_bits(`BOARD_IO_N_SWITCHES, val);
        @(posedge clk);
        sw <= val[`BOARD_IO_N_SWITCHES-1:0];
        wait_cycles(24);
        read_expect(REG_SWITCHES, val, "switches");
        // short glitch still on the pins while the read happens
        sw <= ~val[`BOARD_IO_N_SWITCHES-1:0];
        wait_cycles(8);
        read_expect(REG_SWITCHES, val, "switches during glitch");
        sw <= val[`BOARD_IO_N_SWITCHES-1:0];
        end_test("switch_debounce");

        begin_test();
        @(posedge clk);
        key <= '0;
        wait_cycles(24);
        read_expect(REG_KEYS, (1 << `BOARD_IO_N_KEYS) - 1, "keys pressed");
        key <= '1;
        wait_cycles(24);
        read_expect(REG_KEYS, '0, "keys released");
        end_test("key_inversion");

        begin_test();
        bus_write(REG_BLANK, '0);
        take_bits(4 * `BOARD_IO_N_DIGITS, val);
        bus_write(REG_HEX, val);
        wait_cycles(2);
        for (int d = 0; d < `BOARD_IO_N_DIGITS; d++) begin
            compare("decimal point", hex[d][7], 1'b1);
        end
        read_expect(REG_HEX, val, "hex register");
        end_test("hex_display");

        begin_test();
        take_bits(`BOARD_IO_N_DIGITS, val);
        bus_write(REG_BLANK, val);
        wait_cycles(2);
        for (int d = 0; d < `BOARD_IO_N_DIGITS; d++) begin
            if (val[d]) begin
                compare("blanked digit", hex[d], 8'hFF);
            end
        end
        read_expect(REG_BLANK, val, "blank register");
        end_test("digit_blanking");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: board_io.f
+incdir+logic
logic/board_io_pkg.sv
logic/io_bus_if.sv
logic/input_debouncer.sv
logic/io_reg_file.sv
logic/seven_seg_digit.sv
logic/board_io_top.sv
sim/board_io_assertions.sv
sim/board_io_tb.sv

// File: Bender.yml
package:
  name: board_io

export_include_dirs:
  - logic

sources:
  - files:
      - logic/board_io_pkg.sv
      - logic/io_bus_if.sv
      - logic/input_debouncer.sv
      - logic/io_reg_file.sv
      - logic/seven_seg_digit.sv
      - logic/board_io_top.sv
  - target: simulation
    files:
      - sim/board_io_assertions.sv
      - sim/board_io_tb.sv
